// ==== Makefile ====
SOURCES := verilog.f $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)

.PHONY: run clean

obj_dir/VfastCycleTb: $(SOURCES)
	verilator --binary -Wno-fatal --top-module fastCycleTb -f verilog.f

run: obj_dir/VfastCycleTb
	@out="$$(./obj_dir/VfastCycleTb)"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// ==== rtl/activeListBuffer.sv ====
`default_nettype none

`include "fastCycle_config.svh"

module activeListBuffer
	import fastCyclePkg::*;
(
	input wire logic CLK_24M,
	input wire logic arstN,
	input wire logic hitStrobe,
	input wire spriteIndex_t hitIndex,
	input wire logic scanDone,
	output logic activeStrobe,
	output spriteIndex_t activeIndex,
	output logic listDone,
	output listCount_t activeCount
);

	localparam int IDX_W = $clog2(`FC_ACTIVE_MAX);
	localparam listCount_t LIST_MAX = listCount_t'(`FC_ACTIVE_MAX);

	spriteIndex_t listMem [`FC_ACTIVE_MAX];
	listCount_t fillCount;
	listCount_t readPtr;
	logic streaming;
	logic listFull;

	assign listFull = (fillCount >= LIST_MAX);

	// Hits past capacity are dropped
	always_ff @(posedge CLK_24M) begin
		if (hitStrobe && !listFull) begin
			listMem[fillCount[IDX_W-1:0]] <= hitIndex;
		end
	end

	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			fillCount <= '0;
			readPtr <= '0;
			streaming <= 1'b0;
			activeStrobe <= 1'b0;
			listDone <= 1'b0;
			activeCount <= '0;
		end else begin
			activeStrobe <= 1'b0;
			listDone <= 1'b0;
			if (streaming) begin
				if (readPtr < fillCount) begin
					activeStrobe <= 1'b1;
					readPtr <= readPtr + 1'b1;
				end else begin
					// List empties for the next line
					streaming <= 1'b0;
					listDone <= 1'b1;
					activeCount <= fillCount;
					fillCount <= '0;
					readPtr <= '0;
				end
			end else if (scanDone) begin
				if (fillCount != '0) begin
					streaming <= 1'b1;
					activeStrobe <= 1'b1;
					readPtr <= readPtr + 1'b1;
				end else begin
					listDone <= 1'b1;
					activeCount <= '0;
				end
			end else if (hitStrobe && !listFull) begin
				fillCount <= fillCount + 1'b1;
			end
		end
	end

	// Entry at readPtr, qualified by activeStrobe
	always_ff @(posedge CLK_24M) begin
		activeIndex <= listMem[readPtr[IDX_W-1:0]];
	end

endmodule

`default_nettype wire

// ==== rtl/cpuPortLatch.sv ====
`default_nettype none

module cpuPortLatch
	import fastCyclePkg::*;
(
	input wire logic CLK_24M,
	input wire logic arstN,
	input wire logic cpuWrStrobe,
	input wire cpuWrite_t cpuWr,
	input wire logic cpuGrant,
	output logic pending,
	output cpuWrite_t heldWrite
);

	// Set on strobe, cleared once the arbiter commits the write
	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			pending <= 1'b0;
		end else if (cpuWrStrobe) begin
			pending <= 1'b1;
		end else if (cpuGrant) begin
			pending <= 1'b0;
		end
	end

	// Write word kept until its slot comes round
	always_ff @(posedge CLK_24M) begin
		if (cpuWrStrobe) begin
			heldWrite <= cpuWr;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fastCyclePkg.sv ====
`default_nettype none

`include "fastCycle_config.svh"

package fastCyclePkg;

	// Sprite slot number, also the VRAM address
	typedef logic [`FC_ADDR_WIDTH-1:0] spriteIndex_t;

	// Raster line or sprite Y, modulo 512
	typedef logic [8:0] yPos_t;

	// Height in 16-line tiles, bit 5 forces full coverage
	typedef logic [5:0] spriteSize_t;

	// Y in 15..7, chain in 6, size in 5..0
	typedef logic [15:0] attrWord_t;

	typedef logic [4:0] listCount_t;

	typedef struct packed {
		spriteIndex_t addr;
		attrWord_t data;
	} cpuWrite_t;

	typedef struct packed {
		spriteIndex_t addr;
		attrWord_t wrData;
		logic wrEn;
	} vramReq_t;

	typedef enum logic [1:0] {idle, scan, drain, finish} parseState_t;

endpackage

`default_nettype wire

// ==== rtl/fastCycleTop.sv ====
`default_nettype none

module fastCycleTop
	import fastCyclePkg::*;
(
	input wire logic CLK_24M,
	input wire logic arstN,
	input wire logic cpuWrStrobe,
	input wire cpuWrite_t cpuWr,
	input wire logic lineStart,
	input wire yPos_t rasterLine,
	output logic activeStrobe,
	output spriteIndex_t activeIndex,
	output logic listDone,
	output listCount_t activeCount
);

	logic pending;
	cpuWrite_t heldWrite;
	logic cpuGrant;
	logic parseSlot;
	vramReq_t vramReq;
	attrWord_t rdData;
	spriteIndex_t parseRdAddr;
	logic hitStrobe;
	spriteIndex_t hitIndex;
	logic scanDone;

	cpuPortLatch u_cpuPortLatch (
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.cpuWrStrobe(cpuWrStrobe),
		.cpuWr(cpuWr),
		.cpuGrant(cpuGrant),
		.pending(pending),
		.heldWrite(heldWrite)
	);

	fastSlotArbiter u_fastSlotArbiter (
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.pending(pending),
		.heldWrite(heldWrite),
		.parseRdAddr(parseRdAddr),
		.parseSlot(parseSlot),
		.cpuGrant(cpuGrant),
		.vramReq(vramReq)
	);

	vramFast u_vramFast (
		.CLK_24M(CLK_24M),
		.vramReq(vramReq),
		.rdData(rdData)
	);

	yParser u_yParser (
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.lineStart(lineStart),
		.rasterLine(rasterLine),
		.parseSlot(parseSlot),
		.rdData(rdData),
		.parseRdAddr(parseRdAddr),
		.hitStrobe(hitStrobe),
		.hitIndex(hitIndex),
		.scanDone(scanDone)
	);

	activeListBuffer u_activeListBuffer (
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.hitStrobe(hitStrobe),
		.hitIndex(hitIndex),
		.scanDone(scanDone),
		.activeStrobe(activeStrobe),
		.activeIndex(activeIndex),
		.listDone(listDone),
		.activeCount(activeCount)
	);

endmodule

`default_nettype wire

// ==== rtl/fastCycle_config.svh ====
`ifndef FASTCYCLE_CONFIG_SVH
`define FASTCYCLE_CONFIG_SVH

// Sprite slots held in fast VRAM
`define FC_SPRITE_COUNT 64
`define FC_ADDR_WIDTH 6

// Active list capacity per line
`define FC_ACTIVE_MAX 16

// Lines added to the raster line before the Y match
`define FC_LOOKAHEAD 2

`endif

// ==== rtl/fastSlotArbiter.sv ====
`default_nettype none

module fastSlotArbiter
	import fastCyclePkg::*;
(
	input wire logic CLK_24M,
	input wire logic arstN,
	input wire logic pending,
	input wire cpuWrite_t heldWrite,
	input wire spriteIndex_t parseRdAddr,
	output logic parseSlot,
	output logic cpuGrant,
	output vramReq_t vramReq
);

	spriteIndex_t addrQ;
	attrWord_t dataQ;
	logic wrEnQ;

	// Odd cycles belong to the CPU
	assign cpuGrant = ~parseSlot & pending;

	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			parseSlot <= 1'b1;
			wrEnQ <= 1'b0;
		end else begin
			parseSlot <= ~parseSlot;
			wrEnQ <= cpuGrant;
		end
	end

	// Address mux, parse index unless a CPU write owns the slot
	// A CPU slot with nothing pending becomes an idle read
	always_ff @(posedge CLK_24M) begin
		if (cpuGrant) begin
			addrQ <= heldWrite.addr;
		end else begin
			addrQ <= parseRdAddr;
		end
		dataQ <= heldWrite.data;
	end

	assign vramReq = '{addr: addrQ, wrData: dataQ, wrEn: wrEnQ};

endmodule

`default_nettype wire

// ==== rtl/vramFast.sv ====
`default_nettype none

`include "fastCycle_config.svh"

module vramFast
	import fastCyclePkg::*;
(
	input wire logic CLK_24M,
	input wire vramReq_t vramReq,
	output attrWord_t rdData
);

	attrWord_t mem [`FC_SPRITE_COUNT];

	// Single port, old data is read on a write cycle
	always_ff @(posedge CLK_24M) begin
		if (vramReq.wrEn) begin
			mem[vramReq.addr] <= vramReq.wrData;
		end
		rdData <= mem[vramReq.addr];
	end

endmodule

`default_nettype wire

// ==== rtl/yParser.sv ====
`default_nettype none

`include "fastCycle_config.svh"

module yParser
	import fastCyclePkg::*;
(
	input wire logic CLK_24M,
	input wire logic arstN,
	input wire logic lineStart,
	input wire yPos_t rasterLine,
	input wire logic parseSlot,
	input wire attrWord_t rdData,
	output spriteIndex_t parseRdAddr,
	output logic hitStrobe,
	output spriteIndex_t hitIndex,
	output logic scanDone
);

	localparam spriteIndex_t LAST_INDEX = spriteIndex_t'(`FC_SPRITE_COUNT - 1);
	localparam listCount_t LIST_MAX = listCount_t'(`FC_ACTIVE_MAX);

	parseState_t state;
	yPos_t targetLine;

	// Read pipeline, issue then address register then VRAM data
	logic fetchValid;
	logic wordValid;
	spriteIndex_t fetchIndex;
	spriteIndex_t wordIndex;

	logic lastEval;
	logic prevActive;
	listCount_t hitCount;
	listCount_t waitCount;

	yPos_t wordY;
	yPos_t lineDelta;
	logic wordChain;
	spriteSize_t wordSize;
	logic yMatch;
	logic isActive;

	assign wordY = rdData[15:7];
	assign wordChain = rdData[6];
	assign wordSize = rdData[5:0];

	// Distance into the sprite, wraps at line 511
	assign lineDelta = targetLine - wordY;
	assign yMatch = wordSize[5] | (lineDelta < {wordSize[4:0], 4'b0000});

	// Slot 0 has nothing to chain to
	assign isActive = (wordChain && wordIndex != '0) ? prevActive : yMatch;

	always_ff @(posedge CLK_24M or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			parseRdAddr <= '0;
			fetchValid <= 1'b0;
			wordValid <= 1'b0;
			lastEval <= 1'b0;
			prevActive <= 1'b0;
			hitStrobe <= 1'b0;
			scanDone <= 1'b0;
			hitCount <= '0;
			waitCount <= '0;
		end else begin
			fetchValid <= 1'b0;
			wordValid <= fetchValid;
			hitStrobe <= wordValid & isActive;
			lastEval <= wordValid && (wordIndex == LAST_INDEX);
			scanDone <= 1'b0;

			if (wordValid) begin
				prevActive <= isActive;
				if (isActive && hitCount < LIST_MAX) begin
					hitCount <= hitCount + 1'b1;
				end
			end

			case (state)
				idle: begin
					if (lineStart) begin
						state <= scan;
						parseRdAddr <= '0;
						hitCount <= '0;
						prevActive <= 1'b0;
					end
				end
				scan: begin
					// One read per parse slot
					if (parseSlot) begin
						fetchValid <= 1'b1;
						if (parseRdAddr == LAST_INDEX) begin
							state <= drain;
						end else begin
							parseRdAddr <= parseRdAddr + 1'b1;
						end
					end
				end
				drain: begin
					if (lastEval) begin
						scanDone <= 1'b1;
						waitCount <= hitCount;
						state <= finish;
					end
				end
				finish: begin
					// Hold off new lines while the list streams out
					if (waitCount == '0) begin
						state <= idle;
					end else begin
						waitCount <= waitCount - 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge CLK_24M) begin
		if (lineStart && state == idle) begin
			targetLine <= rasterLine + yPos_t'(`FC_LOOKAHEAD);
		end
		fetchIndex <= parseRdAddr;
		wordIndex <= fetchIndex;
		hitIndex <= wordIndex;
	end

endmodule

`default_nettype wire

// ==== verif/fastCycleTb.sv ====
`default_nettype none

`include "fastCycle_config.svh"

module fastCycleTb
	import fastCyclePkg::*;
();

	logic CLK_24M;
	logic arstN;
	logic cpuWrStrobe;
	cpuWrite_t cpuWr;
	logic lineStart;
	yPos_t rasterLine;
	logic activeStrobe;
	spriteIndex_t activeIndex;
	logic listDone;
	listCount_t activeCount;

	// Mirror of VRAM and the expected list of the current line
	attrWord_t vramModel [`FC_SPRITE_COUNT];
	spriteIndex_t expIdx [`FC_ACTIVE_MAX];
	int expCount;
	int outPos;
	int doneCount;
	int errors;
	int timeouts;
	logic [31:0] seed;

	fastCycleTop u_fastCycleTop (
		.CLK_24M(CLK_24M),
		.arstN(arstN),
		.cpuWrStrobe(cpuWrStrobe),
		.cpuWr(cpuWr),
		.lineStart(lineStart),
		.rasterLine(rasterLine),
		.activeStrobe(activeStrobe),
		.activeIndex(activeIndex),
		.listDone(listDone),
		.activeCount(activeCount)
	);

	initial begin
		CLK_24M = 1'b0;
		forever #2 CLK_24M = ~CLK_24M;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic attrWord_t makeAttr(input int y, input logic chain, input int size);
		return {y[8:0], chain, size[5:0]};
	endfunction

	// Mostly short sprites, a few chained, rare forced ones
	function automatic attrWord_t randomAttr(input logic [31:0] r);
		logic chain;
		logic [5:0] size;
		chain = (r[22:21] == 2'b00);
		size = (r[20:17] == 4'h0) ? 6'h20 : {3'b000, r[18:16]};
		return {r[31:23], chain, size};
	endfunction

	// Reference model of the Y match, chain and capacity rules
	function automatic int expectedList(input yPos_t line);
		int count;
		int d;
		int y;
		int size;
		logic chain;
		logic prev;
		logic hit;
		count = 0;
		prev = 1'b0;
		for (int i = 0; i < `FC_SPRITE_COUNT; i++) begin
			y = int'(vramModel[i][15:7]);
			chain = vramModel[i][6];
			size = int'(vramModel[i][5:0]);
			d = (int'(line) + `FC_LOOKAHEAD - y + 1024) % 512;
			if (chain && i != 0) begin
				hit = prev;
			end else begin
				hit = (size >= 32) || (size != 0 && d < 16 * size);
			end
			if (hit && count < `FC_ACTIVE_MAX) begin
				expIdx[count] = spriteIndex_t'(i);
				count++;
			end
			prev = hit;
		end
		return count;
	endfunction

	task automatic writeSlot(input int slot, input attrWord_t word);
		@(negedge CLK_24M);
		cpuWrStrobe = 1'b1;
		cpuWr = '{addr: spriteIndex_t'(slot), data: word};
		@(negedge CLK_24M);
		cpuWrStrobe = 1'b0;
		// Spacing so the held write reaches a CPU slot
		repeat (3) @(negedge CLK_24M);
		vramModel[slot] = word;
	endtask

	task automatic runLine(input int line);
		int startDone;
		int waited;
		expCount = expectedList(yPos_t'(line));
		startDone = doneCount;
		@(negedge CLK_24M);
		lineStart = 1'b1;
		rasterLine = yPos_t'(line);
		@(negedge CLK_24M);
		lineStart = 1'b0;
		waited = 0;
		while (doneCount == startDone && waited < 400) begin
			@(negedge CLK_24M);
			waited++;
		end
		if (doneCount == startDone) begin
			timeouts++;
			$display("Timed out waiting for listDone on raster line %0d", line);
		end
		repeat (2) @(negedge CLK_24M);
	endtask

	// Compare the streamed list against the model
	always @(negedge CLK_24M) begin
		if (arstN) begin
			if (activeStrobe) begin
				if (outPos >= expCount) begin
					errors++;
					$display("More active entries than the %0d expected", expCount);
				end else if (activeIndex !== expIdx[outPos]) begin
					errors++;
					$display("Fail activeIndex entry %0d: got 0x%h, expected 0x%h",
						outPos, activeIndex, expIdx[outPos]);
				end
				outPos++;
			end
			if (listDone) begin
				if (activeCount !== listCount_t'(expCount)) begin
					errors++;
					$display("Fail activeCount: got 0x%h, expected 0x%h",
						activeCount, listCount_t'(expCount));
				end
				if (outPos != expCount) begin
					errors++;
					$display("List streamed %0d entries but %0d were expected",
						outPos, expCount);
				end
				outPos = 0;
				doneCount++;
			end
		end
	end

	initial begin
		int slot;
		cpuWrStrobe = 1'b0;
		cpuWr = '0;
		lineStart = 1'b0;
		rasterLine = '0;
		arstN = 1'b0;
		errors = 0;
		timeouts = 0;
		outPos = 0;
		doneCount = 0;
		expCount = 0;
		seed = 32'h3758_4f78;
		repeat (5) @(posedge CLK_24M);
		@(negedge CLK_24M);
		arstN = 1'b1;
		@(negedge CLK_24M);
		if (activeStrobe !== 1'b0 || listDone !== 1'b0) begin
			errors++;
			$display("Fail activeStrobe/listDone after reset: got 0x%h/0x%h, expected 0x0",
				activeStrobe, listDone);
		end

		for (int i = 0; i < `FC_SPRITE_COUNT; i++) begin
			writeSlot(i, '0);
		end

		// Basic match
		writeSlot(3, makeAttr(100, 1'b0, 1));
		writeSlot(10, makeAttr(120, 1'b0, 2));
		writeSlot(20, makeAttr(50, 1'b0, 1));
		runLine(98);
		runLine(113);
		runLine(118);
		runLine(48);
		runLine(200);

		// Wrap past line 511 and forced coverage
		writeSlot(5, makeAttr(500, 1'b0, 2));
		writeSlot(6, makeAttr(505, 1'b0, 1));
		writeSlot(40, makeAttr(260, 1'b0, 32));
		runLine(508);
		runLine(3);
		runLine(15);
		runLine(300);

		// Chained slots, slot 0 with its chain bit set
		writeSlot(0, makeAttr(300, 1'b1, 1));
		writeSlot(21, makeAttr(300, 1'b0, 1));
		writeSlot(22, makeAttr(0, 1'b1, 0));
		writeSlot(23, makeAttr(0, 1'b1, 32));
		writeSlot(41, makeAttr(0, 1'b1, 0));
		runLine(298);
		runLine(510);
		runLine(305);

		// Overfull list, then an empty one
		for (int i = 44; i < `FC_SPRITE_COUNT; i++) begin
			writeSlot(i, makeAttr(i * 7, 1'b0, 32));
		end
		runLine(77);
		runLine(400);
		for (int i = 0; i < `FC_SPRITE_COUNT; i++) begin
			writeSlot(i, '0);
		end
		runLine(77);

		// Random contents, then random rewrites of the same lines
		for (int i = 0; i < `FC_SPRITE_COUNT; i++) begin
			seed = lcgNext(seed);
			writeSlot(i, randomAttr(seed));
		end
		repeat (4) begin
			seed = lcgNext(seed);
			runLine(int'(seed[24:16]));
		end
		repeat (4) begin
			seed = lcgNext(seed);
			rasterLine = seed[24:16];
			runLine(int'(seed[24:16]));
			repeat (6) begin
				seed = lcgNext(seed);
				slot = int'(seed[21:16]);
				seed = lcgNext(seed);
				writeSlot(slot, randomAttr(seed));
			end
			runLine(int'(rasterLine));
		end

		$display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/fastCyclePkg.sv
rtl/cpuPortLatch.sv
rtl/fastSlotArbiter.sv
rtl/vramFast.sv
rtl/yParser.sv
rtl/activeListBuffer.sv
rtl/fastCycleTop.sv
verif/fastCycleTb.sv
